/* aes_defines.svh */
`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// data block and round key width
`define AES_BLOCK_W 128

// rounds for a 256-bit key, store holds AES_NR+1 keys
`define AES_NR 14

// entries per handshake buffer
`define AES_FIFO_DEPTH 4

// host tag carried from command to result
`define AES_TAG_W 4

`endif

/* aes_cmd_pkg.sv */
`default_nettype none
`include "aes_defines.svh"

package aes_cmd_pkg;

    // host opcodes
    typedef enum logic [1:0]
    {
        op_key_hi  = 2'd0,
        op_key_lo  = 2'd1,
        op_encrypt = 2'd2
    } aes_op_e;

    // one host command, 134 bits
    typedef struct packed
    {
        aes_op_e                 op;
        logic [`AES_TAG_W-1:0]   tag;
        logic [`AES_BLOCK_W-1:0] data;
    } aes_cmd_t;

    // one result back to the host, 132 bits
    typedef struct packed
    {
        logic [`AES_TAG_W-1:0]   tag;
        logic [`AES_BLOCK_W-1:0] data;
    } aes_res_t;

endpackage

`default_nettype wire

/* aes_cipher_pkg.sv */
`default_nettype none
`include "aes_defines.svh"

package aes_cipher_pkg;

    typedef logic [`AES_BLOCK_W-1:0] aes_round_key_t;

    // forward s-box, entry 0 in the leftmost byte
    localparam logic [0:255][7:0] sbox_table =
    {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    function automatic logic [7:0] sbox(input logic [7:0] b);
        return sbox_table[b];
    endfunction

    // multiply by x in gf(2^8)
    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic logic [31:0] sub_word(input logic [31:0] w);
        return {sbox(w[31:24]), sbox(w[23:16]), sbox(w[15:8]), sbox(w[7:0])};
    endfunction

    // one byte left rotate
    function automatic logic [31:0] rot_word(input logic [31:0] w);
        return {w[23:0], w[31:24]};
    endfunction

    function automatic logic [127:0] sub_bytes(input logic [127:0] s);
        logic [127:0] o;
        for (int i = 0; i < 4; i++)
            o[127 - 32*i -: 32] = sub_word(s[127 - 32*i -: 32]);
        return o;
    endfunction

    // byte i of the block is row i%4, column i/4
    // row r moves left by r columns
    function automatic logic [127:0] shift_rows(input logic [127:0] s);
        logic [127:0] o;
        for (int c = 0; c < 4; c++)
            for (int r = 0; r < 4; r++)
                o[127 - 8*(r + 4*c) -: 8] = s[127 - 8*(r + 4*((c + r) % 4)) -: 8];
        return o;
    endfunction

    // one column times the fixed 02 03 01 01 matrix
    function automatic logic [31:0] mix_word(input logic [31:0] w);
        logic [7:0] a0, a1, a2, a3;
        a0 = w[31:24];
        a1 = w[23:16];
        a2 = w[15:8];
        a3 = w[7:0];
        return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
    endfunction

    function automatic logic [127:0] mix_columns(input logic [127:0] s);
        logic [127:0] o;
        for (int c = 0; c < 4; c++)
            o[127 - 32*c -: 32] = mix_word(s[127 - 32*c -: 32]);
        return o;
    endfunction

endpackage

`default_nettype wire

/* aes_req_fifo.sv */
`timescale 1ns/10ps
`default_nettype none
`include "aes_defines.svh"

module aes_req_fifo #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     resetn,
    input  wire logic     in_req,
    output logic          in_ack,
    input  wire payload_t in_data,
    output logic          out_req,
    input  wire logic     out_ack,
    output payload_t      out_data
);

    localparam int aw = $clog2(`AES_FIFO_DEPTH);
    localparam int cw = $clog2(`AES_FIFO_DEPTH + 1);
    localparam logic [aw-1:0] last_slot = aw'(`AES_FIFO_DEPTH - 1);
    localparam logic [cw-1:0] full_cnt = cw'(`AES_FIFO_DEPTH);

    payload_t        mem [`AES_FIFO_DEPTH];
    logic [aw-1:0]   wr_ptr;
    logic [aw-1:0]   rd_ptr;
    logic [cw-1:0]   count;
    logic            push;
    logic            pop;

    // accept only with a free slot and ack still low from the last transfer
    assign push = in_req && !in_ack && (count != full_cnt);
    // head leaves once the reader acks it
    assign pop = out_req && out_ack;

    // head entry, held steady while out_req is high
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            in_ack  <= 1'b0;
            out_req <= 1'b0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
        end
        else
        begin
            // write side four-phase
            if (push)
            begin
                in_ack <= 1'b1;
                wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
            end
            else if (in_ack && !in_req)
                in_ack <= 1'b0;

            // read side, next offer waits for ack low
            if (pop)
            begin
                out_req <= 1'b0;
                rd_ptr  <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
            end
            else if (!out_req && !out_ack && count != '0)
                out_req <= 1'b1;

            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= in_data;
    end

endmodule

`default_nettype wire

/* aes_key_schedule.sv */
`timescale 1ns/10ps
`default_nettype none
`include "aes_defines.svh"

module aes_key_schedule (
    input  wire logic                        clk,
    input  wire logic                        resetn,
    input  wire logic                        key_load,
    input  wire logic [2*`AES_BLOCK_W-1:0]   key,
    output logic                             keys_ready,
    input  wire logic [3:0]                  rk_addr,
    output aes_cipher_pkg::aes_round_key_t   rk_data
);

    localparam logic [5:0] last_word = 6'd59;

    // round key store, word 4k lands in the top of entry k
    aes_cipher_pkg::aes_round_key_t store [0:`AES_NR];

    // previous eight words, oldest in the top slot
    logic [255:0] win;
    logic [5:0]   word_idx;
    logic [7:0]   rcon;
    logic         busy;
    logic [31:0]  temp;
    logic [31:0]  new_word;

    // word i from words i-1 and i-8
    always_comb
    begin
        if (word_idx[2:0] == 3'd0)
            temp = aes_cipher_pkg::sub_word(aes_cipher_pkg::rot_word(win[31:0]))
                   ^ {rcon, 24'h000000};
        else if (word_idx[2:0] == 3'd4)
            // mid-group substitution of 256-bit keys
            temp = aes_cipher_pkg::sub_word(win[31:0]);
        else
            temp = win[31:0];
        new_word = win[255:224] ^ temp;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy       <= 1'b0;
            word_idx   <= '0;
            rcon       <= 8'h01;
            keys_ready <= 1'b0;
        end
        else if (key_load)
        begin
            // words 0..7 are the key, expansion resumes at 8
            busy       <= 1'b1;
            word_idx   <= 6'd8;
            rcon       <= 8'h01;
            keys_ready <= 1'b0;
        end
        else if (busy)
        begin
            word_idx <= word_idx + 1'b1;
            if (word_idx[2:0] == 3'd0)
                rcon <= {rcon[6:0], 1'b0};
            if (word_idx == last_word)
            begin
                busy       <= 1'b0;
                keys_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (key_load)
        begin
            store[0] <= key[255:128];
            store[1] <= key[127:0];
            win      <= key;
        end
        else if (busy)
        begin
            store[word_idx[5:2]][127 - 32*word_idx[1:0] -: 32] <= new_word;
            win <= {win[223:0], new_word};
        end
    end

    // asynchronous read for the core
    assign rk_data = store[rk_addr];

endmodule

`default_nettype wire

/* aes_enc_core.sv */
`timescale 1ns/10ps
`default_nettype none
`include "aes_defines.svh"

module aes_enc_core (
    input  wire logic                           clk,
    input  wire logic                           resetn,
    input  wire logic                           start,
    input  wire logic [`AES_BLOCK_W-1:0]        block_in,
    output logic [3:0]                          rk_addr,
    input  wire aes_cipher_pkg::aes_round_key_t rk_data,
    output logic                                done,
    output logic [`AES_BLOCK_W-1:0]             block_out
);

    localparam logic [3:0] last_round = 4'(`AES_NR);

    logic [`AES_BLOCK_W-1:0] state;
    logic [`AES_BLOCK_W-1:0] shifted;
    logic [`AES_BLOCK_W-1:0] round_out;
    logic [3:0]              round;
    logic                    busy;

    // idle counter sits at 0, so key 0 is ready for the start cycle
    assign rk_addr = round;

    assign shifted = aes_cipher_pkg::shift_rows(aes_cipher_pkg::sub_bytes(state));

    // final round skips mixcolumns
    assign round_out = (round == last_round) ?
                       shifted ^ rk_data :
                       aes_cipher_pkg::mix_columns(shifted) ^ rk_data;

    // state holds the ciphertext after done
    assign block_out = state;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            busy  <= 1'b0;
            round <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                busy  <= 1'b1;
                round <= 4'd1;
            end
            else if (busy)
            begin
                if (round == last_round)
                begin
                    // done 15 cycles after start
                    busy  <= 1'b0;
                    round <= '0;
                    done  <= 1'b1;
                end
                else
                    round <= round + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            // initial addroundkey
            state <= block_in ^ rk_data;
        else if (busy)
            state <= round_out;
    end

endmodule

`default_nettype wire

/* aes_device.sv */
`timescale 1ns/10ps
`default_nettype none
`include "aes_defines.svh"

module aes_device (
    input  wire logic                      clk,
    input  wire logic                      resetn,
    input  wire logic                      cmd_req,
    output logic                           cmd_ack,
    input  wire aes_cmd_pkg::aes_cmd_t     cmd,
    output logic                           res_req,
    input  wire logic                      res_ack,
    output aes_cmd_pkg::aes_res_t          res,
    output logic                           key_load,
    output logic [2*`AES_BLOCK_W-1:0]      key,
    input  wire logic                      keys_ready,
    output logic                           enc_start,
    output logic [`AES_BLOCK_W-1:0]        enc_block,
    input  wire logic                      enc_done,
    input  wire logic [`AES_BLOCK_W-1:0]   enc_result
);

    typedef enum logic [2:0]
    {
        st_idle,
        st_accept,
        st_wait_keys,
        st_encrypt,
        st_push,
        st_release
    } state_e;

    state_e                state;
    aes_cmd_pkg::aes_cmd_t cmd_q;

    assign enc_block = cmd_q.data;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= st_idle;
            cmd_ack   <= 1'b0;
            res_req   <= 1'b0;
            key_load  <= 1'b0;
            enc_start <= 1'b0;
        end
        else
        begin
            // single-cycle strobes
            key_load  <= 1'b0;
            enc_start <= 1'b0;
            case (state)
                st_idle:
                    if (cmd_req)
                    begin
                        cmd_ack <= 1'b1;
                        state   <= st_accept;
                    end
                st_accept:
                    // finish the handshake, then dispatch on the opcode
                    if (!cmd_req)
                    begin
                        cmd_ack <= 1'b0;
                        case (cmd_q.op)
                            aes_cmd_pkg::op_key_lo:
                            begin
                                // second seed complete, expand it
                                key_load <= 1'b1;
                                state    <= st_idle;
                            end
                            aes_cmd_pkg::op_encrypt:
                                state <= st_wait_keys;
                            default:
                                state <= st_idle;
                        endcase
                    end
                st_wait_keys:
                    // hold the block until the round keys are complete
                    if (keys_ready)
                    begin
                        enc_start <= 1'b1;
                        state     <= st_encrypt;
                    end
                st_encrypt:
                    if (enc_done)
                    begin
                        res_req <= 1'b1;
                        state   <= st_push;
                    end
                st_push:
                    // stalls here while the result buffer is full
                    if (res_ack)
                    begin
                        res_req <= 1'b0;
                        state   <= st_release;
                    end
                st_release:
                    if (!res_ack)
                        state <= st_idle;
                default:
                    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        // command stays stable while cmd_req is high
        if (state == st_idle && cmd_req)
            cmd_q <= cmd;
        if (state == st_accept && !cmd_req)
        begin
            if (cmd_q.op == aes_cmd_pkg::op_key_hi)
                key[255:128] <= cmd_q.data;
            else if (cmd_q.op == aes_cmd_pkg::op_key_lo)
                key[127:0] <= cmd_q.data;
        end
        // result goes out with the command's tag
        if (state == st_encrypt && enc_done)
        begin
            res.tag  <= cmd_q.tag;
            res.data <= enc_result;
        end
    end

endmodule

`default_nettype wire

/* aes_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "aes_defines.svh"

module aes_top (
    input  wire logic                  clk,
    input  wire logic                  resetn,
    input  wire logic                  cmd_req,
    output wire logic                  cmd_ack,
    input  wire aes_cmd_pkg::aes_cmd_t cmd,
    output wire logic                  res_req,
    input  wire logic                  res_ack,
    output wire aes_cmd_pkg::aes_res_t res
);

    // command buffer to controller
    logic                           dev_cmd_req;
    logic                           dev_cmd_ack;
    aes_cmd_pkg::aes_cmd_t          dev_cmd;

    // controller to result buffer
    logic                           dev_res_req;
    logic                           dev_res_ack;
    aes_cmd_pkg::aes_res_t          dev_res;

    // key schedule and core
    logic                           key_load;
    logic [2*`AES_BLOCK_W-1:0]      key;
    logic                           keys_ready;
    logic [3:0]                     rk_addr;
    aes_cipher_pkg::aes_round_key_t rk_data;
    logic                           enc_start;
    logic [`AES_BLOCK_W-1:0]        enc_block;
    logic                           enc_done;
    logic [`AES_BLOCK_W-1:0]        enc_result;

    aes_req_fifo #(.payload_t(aes_cmd_pkg::aes_cmd_t)) cmd_fifo (
        .clk      (clk),
        .resetn   (resetn),
        .in_req   (cmd_req),
        .in_ack   (cmd_ack),
        .in_data  (cmd),
        .out_req  (dev_cmd_req),
        .out_ack  (dev_cmd_ack),
        .out_data (dev_cmd)
    );

    aes_device device (
        .clk        (clk),
        .resetn     (resetn),
        .cmd_req    (dev_cmd_req),
        .cmd_ack    (dev_cmd_ack),
        .cmd        (dev_cmd),
        .res_req    (dev_res_req),
        .res_ack    (dev_res_ack),
        .res        (dev_res),
        .key_load   (key_load),
        .key        (key),
        .keys_ready (keys_ready),
        .enc_start  (enc_start),
        .enc_block  (enc_block),
        .enc_done   (enc_done),
        .enc_result (enc_result)
    );

    aes_key_schedule key_schedule (
        .clk        (clk),
        .resetn     (resetn),
        .key_load   (key_load),
        .key        (key),
        .keys_ready (keys_ready),
        .rk_addr    (rk_addr),
        .rk_data    (rk_data)
    );

    aes_enc_core enc_core (
        .clk       (clk),
        .resetn    (resetn),
        .start     (enc_start),
        .block_in  (enc_block),
        .rk_addr   (rk_addr),
        .rk_data   (rk_data),
        .done      (enc_done),
        .block_out (enc_result)
    );

    // read side drives the host result port
    aes_req_fifo #(.payload_t(aes_cmd_pkg::aes_res_t)) res_fifo (
        .clk      (clk),
        .resetn   (resetn),
        .in_req   (dev_res_req),
        .in_ack   (dev_res_ack),
        .in_data  (dev_res),
        .out_req  (res_req),
        .out_ack  (res_ack),
        .out_data (res)
    );

endmodule

`default_nettype wire

/* tb_aes_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_aes_asserts (
    input wire logic                  clk,
    input wire logic                  resetn,
    input wire logic                  cmd_req,
    input wire logic                  cmd_ack,
    input wire aes_cmd_pkg::aes_cmd_t cmd,
    input wire logic                  res_req,
    input wire logic                  res_ack,
    input wire aes_cmd_pkg::aes_res_t res
);

    // req on the host command port holds until ack
    cmd_req_held: assert property (@(posedge clk) disable iff (!resetn)
        cmd_req && !cmd_ack |=> cmd_req || cmd_ack)
        else $error("cmd_req dropped before cmd_ack");

    cmd_data_stable: assert property (@(posedge clk) disable iff (!resetn)
        cmd_req && $past(cmd_req) |-> $stable(cmd))
        else $error("cmd changed while cmd_req was high");

    // ack only answers a pending req
    cmd_ack_needs_req: assert property (@(posedge clk) disable iff (!resetn)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose without cmd_req");

    // device side sends on the result port
    res_req_held: assert property (@(posedge clk) disable iff (!resetn)
        res_req && !res_ack |=> res_req || res_ack)
        else $error("res_req dropped before res_ack");

    res_data_stable: assert property (@(posedge clk) disable iff (!resetn)
        res_req && $past(res_req) |-> $stable(res))
        else $error("res changed while res_req was high");

    // host may ack in the cycle it first sees req
    res_ack_needs_req: assert property (@(posedge clk) disable iff (!resetn)
        $rose(res_ack) |-> res_req)
        else $error("res_ack rose without res_req");

endmodule

bind aes_top tb_aes_asserts asserts (
    .clk     (clk),
    .resetn  (resetn),
    .cmd_req (cmd_req),
    .cmd_ack (cmd_ack),
    .cmd     (cmd),
    .res_req (res_req),
    .res_ack (res_ack),
    .res     (res)
);

`default_nettype wire

/* tb_aes_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "aes_defines.svh"

module tb_aes_top;

    localparam int max_cmds = 64;
    // cycles any single wait may take
    localparam int wait_limit = 1000;
    // long hold on this result backs up both buffers
    localparam logic [`AES_TAG_W-1:0] stall_tag = 4'h7;
    localparam int stall_cycles = 200;

    logic                    clk;
    logic                    resetn;
    logic                    cmd_req;
    logic                    cmd_ack;
    aes_cmd_pkg::aes_cmd_t   cmd;
    logic                    res_req;
    logic                    res_ack;
    aes_cmd_pkg::aes_res_t   res;

    // four words per command: op, tag, data, expected
    logic [`AES_BLOCK_W-1:0] pat [0:4*max_cmds-1];
    aes_cmd_pkg::aes_cmd_t   cmd_q[$];
    aes_cmd_pkg::aes_res_t   exp_q[$];
    int                      errors;
    int                      timeouts;
    int                      received;

    aes_top uut (
        .clk     (clk),
        .resetn  (resetn),
        .cmd_req (cmd_req),
        .cmd_ack (cmd_ack),
        .cmd     (cmd),
        .res_req (res_req),
        .res_ack (res_ack),
        .res     (res)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // drive and sample point, 5 ns past the edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic check_value(input string name, input logic [`AES_BLOCK_W-1:0] expected,
                               input logic [`AES_BLOCK_W-1:0] actual);
        if (actual !== expected)
        begin
            errors++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timed out waiting for %s", what);
    endtask

    // host side four-phase write
    task automatic send_cmd(input aes_cmd_pkg::aes_cmd_t c);
        int n;
        cmd     = c;
        cmd_req = 1'b1;
        n = 0;
        while (cmd_ack !== 1'b1 && n < wait_limit)
        begin
            next_cycle();
            n++;
        end
        if (cmd_ack !== 1'b1)
            report_timeout($sformatf("cmd_ack to rise, command tag %0h", c.tag));
        cmd_req = 1'b0;
        n = 0;
        while (cmd_ack !== 1'b0 && n < wait_limit)
        begin
            next_cycle();
            n++;
        end
        if (cmd_ack !== 1'b0)
            report_timeout("cmd_ack to fall");
    endtask

    // results in command order, random ack delay
    task automatic take_results();
        aes_cmd_pkg::aes_res_t exp;
        int n;
        int delay;
        for (int i = 0; i < exp_q.size(); i++)
        begin
            exp = exp_q[i];
            n = 0;
            while (res_req !== 1'b1 && n < wait_limit)
            begin
                next_cycle();
                n++;
            end
            if (res_req !== 1'b1)
            begin
                report_timeout($sformatf("result %0d", i));
                return;
            end
            received++;
            check_value($sformatf("result %0d tag", i), exp.tag, res.tag);
            check_value($sformatf("result %0d data", i), exp.data, res.data);
            delay = (exp.tag == stall_tag) ? stall_cycles : $urandom_range(6, 0);
            repeat (delay) next_cycle();
            res_ack = 1'b1;
            n = 0;
            while (res_req !== 1'b0 && n < wait_limit)
            begin
                next_cycle();
                n++;
            end
            if (res_req !== 1'b0)
                report_timeout("res_req to fall");
            res_ack = 1'b0;
        end
    endtask

    // nothing more may come out after the last result
    task automatic check_no_extra();
        for (int n = 0; n < 100; n++)
        begin
            next_cycle();
            if (res_req === 1'b1)
            begin
                errors++;
                $display("an extra result was offered after the last expected one");
                return;
            end
        end
    endtask

    initial
    begin
        aes_cmd_pkg::aes_cmd_t c;
        aes_cmd_pkg::aes_res_t r;
        errors   = 0;
        timeouts = 0;
        received = 0;
        resetn   = 1'b0;
        cmd_req  = 1'b0;
        cmd      = '0;
        res_ack  = 1'b0;
        void'($urandom(83969));
        for (int i = 0; i < 4*max_cmds; i++)
            pat[i] = '1;
        $readmemh("aes_patterns.txt", pat);
        // all ones in the op column marks the end of the file
        for (int i = 0; i < max_cmds && pat[4*i] != '1; i++)
        begin
            c.op   = aes_cmd_pkg::aes_op_e'(pat[4*i][1:0]);
            c.tag  = pat[4*i+1][`AES_TAG_W-1:0];
            c.data = pat[4*i+2];
            cmd_q.push_back(c);
            if (c.op == aes_cmd_pkg::op_encrypt)
            begin
                r.tag  = c.tag;
                r.data = pat[4*i+3];
                exp_q.push_back(r);
            end
        end
        if (exp_q.size() == 0)
        begin
            errors++;
            $display("no encrypt commands were read from aes_patterns.txt");
        end
        repeat (3) @(posedge clk);
        #5;
        check_value("reset cmd_ack", '0, cmd_ack);
        check_value("reset res_req", '0, res_req);
        resetn = 1'b1;
        next_cycle();
        check_value("idle cmd_ack", '0, cmd_ack);
        check_value("idle res_req", '0, res_req);
        fork
            begin
                foreach (cmd_q[i])
                    send_cmd(cmd_q[i]);
            end
            take_results();
        join
        check_no_extra();
        $display("results %0d of %0d, errors %0d, timeouts %0d",
                 received, exp_q.size(), errors, timeouts);
        if (errors == 0 && timeouts == 0 && received == exp_q.size())
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* aes_patterns.txt */
// columns: opcode, tag, data block, expected ciphertext, all hex
// opcode 0 key_hi, 1 key_lo, 2 encrypt; key commands carry 0 as expected
0 0 000102030405060708090a0b0c0d0e0f 0
1 0 101112131415161718191a1b1c1d1e1f 0
2 1 00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
0 0 603deb1015ca71be2b73aef0857d7781 0
1 0 1f352c073b6108d72d9810a30914dff4 0
2 2 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8
2 3 ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870
2 4 30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d
2 5 f69f2445df4f9b17ad2b417be66c3710 23304b7a39f9f3ff067d8d8f9e24ecc7
0 0 000102030405060708090a0b0c0d0e0f 0
1 0 101112131415161718191a1b1c1d1e1f 0
2 6 00112233445566778899aabbccddeeff 8ea2b7ca516745bfeafc49904b496089
0 0 603deb1015ca71be2b73aef0857d7781 0
1 0 1f352c073b6108d72d9810a30914dff4 0
2 7 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8
2 8 ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870
2 9 30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d
2 a f69f2445df4f9b17ad2b417be66c3710 23304b7a39f9f3ff067d8d8f9e24ecc7
2 b 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8
2 c ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870
2 d 30c81c46a35ce411e5fbc1191a0a52ef b6ed21b99ca6f4f9f153e7b1beafed1d
2 e f69f2445df4f9b17ad2b417be66c3710 23304b7a39f9f3ff067d8d8f9e24ecc7
2 f 6bc1bee22e409f96e93d7e117393172a f3eed1bdb5d2a03c064b5a7e3db181f8
2 1 ae2d8a571e03ac9c9eb76fac45af8e51 591ccb10d410ed26dc5ba74a31362870

/* vlog.f */
+incdir+.
aes_cmd_pkg.sv
aes_cipher_pkg.sv
aes_req_fifo.sv
aes_key_schedule.sv
aes_enc_core.sv
aes_device.sv
aes_top.sv
tb_aes_asserts.sv
tb_aes_top.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tb_aes_top
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
